// ==== src/dcache_mem_pkg.sv ====
////////////////////////////////////////
// geometry constants of the write-through
// dcache memory: ports, ways, sets, tag,
// word, line and offset widths
////////////////////////////////////////

`default_nettype none

package dcache_mem_pkg;

  // read ports into the arbiter
  localparam int unsigned NUM_PORTS = 3;

  // set-associative organisation
  localparam int unsigned NUM_WAYS  = 4;
  localparam int unsigned NUM_SETS  = 16;
  localparam int unsigned IDX_WIDTH = 4;
  localparam int unsigned TAG_WIDTH = 8;

  // one cache word per data bank
  localparam int unsigned WORD_WIDTH = 32;
  localparam int unsigned WORD_BYTES = 4;
  localparam int unsigned NUM_BANKS  = 4;

  // full cache line
  localparam int unsigned LINE_WIDTH = 128;
  localparam int unsigned LINE_BYTES = 16;

  // byte offset in a line, upper bits pick the bank
  localparam int unsigned OFFSET_WIDTH   = 4;
  localparam int unsigned BANK_SEL_WIDTH = 2;

  // granted port number
  localparam int unsigned PORT_SEL_WIDTH = 2;

endpackage

`default_nettype wire

// ==== src/dcache_read_arbiter.sv ====
////////////////////////////////////////
// read arbiter: priority masking, round
// robin grant and selection of the
// granted port's index, offset and tag
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dcache_read_arbiter import dcache_mem_pkg::*; (
  input  wire logic                                    clk_i,
  input  wire logic                                    rst_ni,
  input  wire logic [NUM_PORTS-1:0]                    rd_req_i,
  input  wire logic [NUM_PORTS-1:0]                    rd_prio_i,
  input  wire logic [NUM_PORTS-1:0]                    rd_tag_only_i,
  input  wire logic [NUM_PORTS-1:0][IDX_WIDTH-1:0]     rd_idx_i,
  input  wire logic [NUM_PORTS-1:0][OFFSET_WIDTH-1:0]  rd_off_i,
  input  wire logic [NUM_PORTS-1:0][TAG_WIDTH-1:0]     rd_tag_i,
  input  wire logic                                    wr_cl_vld_i,
  output logic      [NUM_PORTS-1:0]                    rd_ack_o,
  output logic                                         rd_gnt_o,
  output logic      [IDX_WIDTH-1:0]                    sel_idx_o,
  output logic      [OFFSET_WIDTH-1:0]                 sel_off_o,
  output logic      [TAG_WIDTH-1:0]                    sel_tag_o,
  output logic                                         sel_tag_only_o
);

  logic [NUM_PORTS-1:0]      req_prio;
  logic [NUM_PORTS-1:0]      req_masked;
  logic [PORT_SEL_WIDTH-1:0] rr_q;
  logic [PORT_SEL_WIDTH-1:0] gnt_idx;
  logic [PORT_SEL_WIDTH-1:0] gnt_port_q;
  logic                      gnt_found;

  // high prio requesters shut out the low prio ones
  assign req_prio   = rd_req_i & rd_prio_i;
  assign req_masked = (|req_prio) ? req_prio : rd_req_i;

  // first competing port at or after the pointer with wraparound
  always_comb begin : p_rr_search
    int port;
    gnt_found = 1'b0;
    gnt_idx   = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      port = (int'(rr_q) + i) % NUM_PORTS;
      if (!gnt_found && req_masked[port]) begin
        gnt_found = 1'b1;
        gnt_idx   = PORT_SEL_WIDTH'(port);
      end
    end
  end

  // a line write stalls every read
  assign rd_gnt_o = gnt_found & ~wr_cl_vld_i;
  assign rd_ack_o = rd_gnt_o ? NUM_PORTS'(1) << gnt_idx : '0;

  assign sel_idx_o      = rd_idx_i[gnt_idx];
  assign sel_off_o      = rd_off_i[gnt_idx];
  assign sel_tag_only_o = rd_tag_only_i[gnt_idx];
  // tag arrives one cycle after the grant
  assign sel_tag_o      = rd_tag_i[gnt_port_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q       <= '0;
      gnt_port_q <= '0;
    end else if (rd_gnt_o) begin
      rr_q       <= (gnt_idx == PORT_SEL_WIDTH'(NUM_PORTS - 1)) ? '0 : gnt_idx + 1'b1;
      gnt_port_q <= gnt_idx;
    end
  end

  // a low prio port never wins against a high prio requester
  ack_prio: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|(rd_req_i & rd_prio_i)) |-> ((rd_ack_o & ~rd_prio_i) == '0))
    else $error("read ack went to a low priority port");

endmodule

`default_nettype wire

// ==== src/dcache_bank_ctrl.sv ====
////////////////////////////////////////
// bank controller: per bank request,
// write enable, index, data and byte
// enables from line write, granted read
// and word write, with collision check
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dcache_bank_ctrl import dcache_mem_pkg::*; (
  input  wire logic                                              wr_cl_vld_i,
  input  wire logic [NUM_WAYS-1:0]                               wr_cl_we_i,
  input  wire logic [IDX_WIDTH-1:0]                              wr_cl_idx_i,
  input  wire logic [LINE_WIDTH-1:0]                             wr_cl_data_i,
  input  wire logic [LINE_BYTES-1:0]                             wr_cl_be_i,
  input  wire logic                                              rd_gnt_i,
  input  wire logic [IDX_WIDTH-1:0]                              sel_idx_i,
  input  wire logic [OFFSET_WIDTH-1:0]                           sel_off_i,
  input  wire logic                                              sel_tag_only_i,
  input  wire logic [NUM_WAYS-1:0]                               wr_req_i,
  input  wire logic [IDX_WIDTH-1:0]                              wr_idx_i,
  input  wire logic [OFFSET_WIDTH-1:0]                           wr_off_i,
  input  wire logic [WORD_WIDTH-1:0]                             wr_data_i,
  input  wire logic [WORD_BYTES-1:0]                             wr_be_i,
  output logic                                                   wr_ack_o,
  output logic      [NUM_BANKS-1:0]                              bank_req_o,
  output logic      [NUM_BANKS-1:0]                              bank_we_o,
  output logic      [NUM_BANKS-1:0][IDX_WIDTH-1:0]               bank_idx_o,
  output logic      [NUM_BANKS-1:0][NUM_WAYS-1:0][WORD_WIDTH-1:0] bank_wdata_o,
  output logic      [NUM_BANKS-1:0][NUM_WAYS-1:0][WORD_BYTES-1:0] bank_be_o
);

  logic [BANK_SEL_WIDTH-1:0] rd_bank;
  logic [BANK_SEL_WIDTH-1:0] wr_bank;
  logic                      rd_data;
  logic                      collision;

  // word offset is the bank number
  assign rd_bank = sel_off_i[OFFSET_WIDTH-1 -: BANK_SEL_WIDTH];
  assign wr_bank = wr_off_i[OFFSET_WIDTH-1 -: BANK_SEL_WIDTH];

  // tag-only reads leave the data banks alone
  assign rd_data   = rd_gnt_i & ~sel_tag_only_i;
  assign collision = rd_data & (rd_bank == wr_bank);
  assign wr_ack_o  = (|wr_req_i) & ~wr_cl_vld_i & ~collision;

  always_comb begin : p_bank
    logic rd_hit_bank;
    logic wr_hit_bank;
    for (int k = 0; k < NUM_BANKS; k++) begin
      rd_hit_bank = rd_data && (rd_bank == BANK_SEL_WIDTH'(k));
      wr_hit_bank = wr_ack_o && (wr_bank == BANK_SEL_WIDTH'(k));
      if (wr_cl_vld_i) begin
        // word k of the line into every enabled way
        bank_req_o[k] = 1'b1;
        bank_we_o[k]  = 1'b1;
        bank_idx_o[k] = wr_cl_idx_i;
        for (int j = 0; j < NUM_WAYS; j++) begin
          bank_wdata_o[k][j] = wr_cl_data_i[k*WORD_WIDTH +: WORD_WIDTH];
          bank_be_o[k][j]    = wr_cl_we_i[j] ? wr_cl_be_i[k*WORD_BYTES +: WORD_BYTES] : '0;
        end
      end else begin
        bank_req_o[k] = rd_hit_bank | wr_hit_bank;
        bank_we_o[k]  = wr_hit_bank;
        bank_idx_o[k] = wr_hit_bank ? wr_idx_i : sel_idx_i;
        for (int j = 0; j < NUM_WAYS; j++) begin
          bank_wdata_o[k][j] = wr_data_i;
          bank_be_o[k][j]    = (wr_hit_bank && wr_req_i[j]) ? wr_be_i : '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/dcache_data_bank.sv ====
////////////////////////////////////////
// data bank: one word of every way per
// set, byte enables, one cycle read
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dcache_data_bank import dcache_mem_pkg::*; (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_ni,
  input  wire logic                                 req_i,
  input  wire logic                                 we_i,
  input  wire logic [IDX_WIDTH-1:0]                 idx_i,
  input  wire logic [NUM_WAYS-1:0][WORD_WIDTH-1:0]  wdata_i,
  input  wire logic [NUM_WAYS-1:0][WORD_BYTES-1:0]  be_i,
  output logic      [NUM_WAYS-1:0][WORD_WIDTH-1:0]  rdata_o
);

  logic [NUM_WAYS-1:0][WORD_WIDTH-1:0] mem_q [NUM_SETS];

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        for (int b = 0; b < WORD_BYTES; b++) begin
          if (be_i[w][b]) begin
            mem_q[idx_i][w][8*b +: 8] <= wdata_i[w][8*b +: 8];
          end
        end
      end
    end
  end

  // read port holds its word until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= mem_q[idx_i];
    end
  end

endmodule

`default_nettype wire

// ==== src/dcache_tag_array.sv ====
////////////////////////////////////////
// tag and valid storage of all ways,
// tag comparison and one-hot hit bits
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array import dcache_mem_pkg::*; (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  wr_cl_vld_i,
  input  wire logic [NUM_WAYS-1:0]   wr_cl_we_i,
  input  wire logic [IDX_WIDTH-1:0]  wr_cl_idx_i,
  input  wire logic [TAG_WIDTH-1:0]  wr_cl_tag_i,
  input  wire logic [NUM_WAYS-1:0]   wr_vld_bits_i,
  input  wire logic                  rd_gnt_i,
  input  wire logic [IDX_WIDTH-1:0]  sel_idx_i,
  input  wire logic [TAG_WIDTH-1:0]  sel_tag_i,
  output logic      [NUM_WAYS-1:0]   rd_vld_bits_o,
  output logic      [NUM_WAYS-1:0]   rd_hit_oh_o
);

  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tag_q [NUM_SETS];
  logic [NUM_SETS-1:0][NUM_WAYS-1:0]  valid_q;
  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tag_rd_q;
  logic [IDX_WIDTH-1:0]               addr;
  logic                               rd_en;
  logic                               cmp_en_q;

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  assign addr  = wr_cl_vld_i ? wr_cl_idx_i : sel_idx_i;
  assign rd_en = rd_gnt_i & ~wr_cl_vld_i;

  always_ff @(posedge clk_i) begin
    if (wr_cl_vld_i) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (wr_cl_we_i[w]) begin
          tag_q[addr][w] <= wr_cl_tag_i;
        end
      end
    end
    if (rd_en) begin
      tag_rd_q <= tag_q[addr];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q       <= '0;
      rd_vld_bits_o <= '0;
      cmp_en_q      <= 1'b0;
    end else begin
      cmp_en_q <= rd_en;
      if (wr_cl_vld_i) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          if (wr_cl_we_i[w]) begin
            valid_q[addr][w] <= wr_vld_bits_i[w];
          end
        end
      end else if (rd_en) begin
        rd_vld_bits_o <= valid_q[addr];
      end
    end
  end

  ////////////////////////////////////////
  // compare against the late tag
  ////////////////////////////////////////

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      rd_hit_oh_o[w] = cmp_en_q & rd_vld_bits_o[w] & (tag_rd_q[w] == sel_tag_i);
    end
  end

  // a tag is never allocated twice in one set
  hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_en |=> $onehot0(rd_hit_oh_o))
    else $error("tag hit bits are not onehot0");

endmodule

`default_nettype wire

// ==== src/dcache_read_mux.sv ====
////////////////////////////////////////
// read word selection: registered bank
// number, AND-OR way mux on hit bits
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dcache_read_mux import dcache_mem_pkg::*; (
  input  wire logic                                                clk_i,
  input  wire logic                                                rst_ni,
  input  wire logic                                                rd_gnt_i,
  input  wire logic [OFFSET_WIDTH-1:0]                             sel_off_i,
  input  wire logic [NUM_BANKS-1:0][NUM_WAYS-1:0][WORD_WIDTH-1:0]  bank_rdata_i,
  input  wire logic [NUM_WAYS-1:0]                                 rd_hit_oh_i,
  output logic      [WORD_WIDTH-1:0]                               rd_data_o
);

  logic [BANK_SEL_WIDTH-1:0] bank_q;
  logic                      data_vld_q;

  // only data reads arrive here, tag-only ones give 0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bank_q     <= '0;
      data_vld_q <= 1'b0;
    end else begin
      data_vld_q <= rd_gnt_i;
      if (rd_gnt_i) begin
        bank_q <= sel_off_i[OFFSET_WIDTH-1 -: BANK_SEL_WIDTH];
      end
    end
  end

  // zero when no way hits
  always_comb begin
    rd_data_o = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      rd_data_o |= bank_rdata_i[bank_q][w] & {WORD_WIDTH{rd_hit_oh_i[w] & data_vld_q}};
    end
  end

endmodule

`default_nettype wire

// ==== src/dcache_mem_top.sv ====
////////////////////////////////////////
// write-through dcache memory top: read
// arbiter, bank controller, data banks,
// tag array and read word mux
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dcache_mem_top import dcache_mem_pkg::*; (
  input  wire logic                                    clk_i,
  input  wire logic                                    rst_ni,
  // read ports
  input  wire logic [NUM_PORTS-1:0]                    rd_req_i,
  input  wire logic [NUM_PORTS-1:0]                    rd_prio_i,
  input  wire logic [NUM_PORTS-1:0]                    rd_tag_only_i,
  input  wire logic [NUM_PORTS-1:0][IDX_WIDTH-1:0]     rd_idx_i,
  input  wire logic [NUM_PORTS-1:0][OFFSET_WIDTH-1:0]  rd_off_i,
  input  wire logic [NUM_PORTS-1:0][TAG_WIDTH-1:0]     rd_tag_i,
  output logic      [NUM_PORTS-1:0]                    rd_ack_o,
  output logic      [NUM_WAYS-1:0]                     rd_vld_bits_o,
  output logic      [NUM_WAYS-1:0]                     rd_hit_oh_o,
  output logic      [WORD_WIDTH-1:0]                   rd_data_o,
  // line write
  input  wire logic                                    wr_cl_vld_i,
  input  wire logic [NUM_WAYS-1:0]                     wr_cl_we_i,
  input  wire logic [IDX_WIDTH-1:0]                    wr_cl_idx_i,
  input  wire logic [TAG_WIDTH-1:0]                    wr_cl_tag_i,
  input  wire logic [LINE_WIDTH-1:0]                   wr_cl_data_i,
  input  wire logic [LINE_BYTES-1:0]                   wr_cl_be_i,
  input  wire logic [NUM_WAYS-1:0]                     wr_vld_bits_i,
  // word write
  input  wire logic [NUM_WAYS-1:0]                     wr_req_i,
  input  wire logic [IDX_WIDTH-1:0]                    wr_idx_i,
  input  wire logic [OFFSET_WIDTH-1:0]                 wr_off_i,
  input  wire logic [WORD_WIDTH-1:0]                   wr_data_i,
  input  wire logic [WORD_BYTES-1:0]                   wr_be_i,
  output logic                                         wr_ack_o
);

  logic                                               rd_gnt;
  logic                                               rd_data_gnt;
  logic [IDX_WIDTH-1:0]                               sel_idx;
  logic [OFFSET_WIDTH-1:0]                            sel_off;
  logic [TAG_WIDTH-1:0]                               sel_tag;
  logic                                               sel_tag_only;
  logic [NUM_BANKS-1:0]                               bank_req;
  logic [NUM_BANKS-1:0]                               bank_we;
  logic [NUM_BANKS-1:0][IDX_WIDTH-1:0]                bank_idx;
  logic [NUM_BANKS-1:0][NUM_WAYS-1:0][WORD_WIDTH-1:0] bank_wdata;
  logic [NUM_BANKS-1:0][NUM_WAYS-1:0][WORD_BYTES-1:0] bank_be;
  logic [NUM_BANKS-1:0][NUM_WAYS-1:0][WORD_WIDTH-1:0] bank_rdata;

  // reads that touch a data bank
  assign rd_data_gnt = rd_gnt & ~sel_tag_only;

  dcache_read_arbiter i_read_arbiter (
    .clk_i, .rst_ni, .rd_req_i, .rd_prio_i, .rd_tag_only_i,
    .rd_idx_i, .rd_off_i, .rd_tag_i, .wr_cl_vld_i, .rd_ack_o,
    .rd_gnt_o       (rd_gnt),
    .sel_idx_o      (sel_idx),
    .sel_off_o      (sel_off),
    .sel_tag_o      (sel_tag),
    .sel_tag_only_o (sel_tag_only)
  );

  dcache_bank_ctrl i_bank_ctrl (
    .wr_cl_vld_i, .wr_cl_we_i, .wr_cl_idx_i, .wr_cl_data_i, .wr_cl_be_i,
    .rd_gnt_i       (rd_gnt),
    .sel_idx_i      (sel_idx),
    .sel_off_i      (sel_off),
    .sel_tag_only_i (sel_tag_only),
    .wr_req_i, .wr_idx_i, .wr_off_i, .wr_data_i, .wr_be_i, .wr_ack_o,
    .bank_req_o     (bank_req),
    .bank_we_o      (bank_we),
    .bank_idx_o     (bank_idx),
    .bank_wdata_o   (bank_wdata),
    .bank_be_o      (bank_be)
  );

  for (genvar k = 0; k < NUM_BANKS; k++) begin : gen_data_banks
    dcache_data_bank i_data_bank (
      .clk_i, .rst_ni,
      .req_i   (bank_req[k]),
      .we_i    (bank_we[k]),
      .idx_i   (bank_idx[k]),
      .wdata_i (bank_wdata[k]),
      .be_i    (bank_be[k]),
      .rdata_o (bank_rdata[k])
    );
  end

  dcache_tag_array i_tag_array (
    .clk_i, .rst_ni, .wr_cl_vld_i, .wr_cl_we_i, .wr_cl_idx_i,
    .wr_cl_tag_i, .wr_vld_bits_i,
    .rd_gnt_i  (rd_gnt),
    .sel_idx_i (sel_idx),
    .sel_tag_i (sel_tag),
    .rd_vld_bits_o, .rd_hit_oh_o
  );

  dcache_read_mux i_read_mux (
    .clk_i, .rst_ni,
    .rd_gnt_i     (rd_data_gnt),
    .sel_off_i    (sel_off),
    .bank_rdata_i (bank_rdata),
    .rd_hit_oh_i  (rd_hit_oh_o),
    .rd_data_o
  );

endmodule

`default_nettype wire

// ==== verif/dcache_mem_tests.svh ====
////////////////////////////////////////
// directed tests of the dcache memory:
// fill and hit, miss and tag-only, read
// arbitration, word write and collision,
// invalidate and overlapping reads
////////////////////////////////////////

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  // puts a line write on the inputs and updates the model
  task automatic drive_line(input logic [IDX_WIDTH-1:0] idx, input logic [NUM_WAYS-1:0] ways,
      input logic [TAG_WIDTH-1:0] tag, input logic [LINE_WIDTH-1:0] line,
      input logic [NUM_WAYS-1:0] vld);
    wr_cl_vld_i   = 1'b1;
    wr_cl_we_i    = ways;
    wr_cl_idx_i   = idx;
    wr_cl_tag_i   = tag;
    wr_cl_data_i  = line;
    wr_cl_be_i    = '1;
    wr_vld_bits_i = vld;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (ways[w]) begin
        model_tag[idx][w] = tag;
        model_vld[idx][w] = vld[w];
        for (int k = 0; k < NUM_BANKS; k++) begin
          model_word[idx][w][k] = line[k*WORD_WIDTH +: WORD_WIDTH];
        end
      end
    end
  endtask

  task automatic write_line(input logic [IDX_WIDTH-1:0] idx, input logic [NUM_WAYS-1:0] ways,
      input logic [TAG_WIDTH-1:0] tag, input logic [LINE_WIDTH-1:0] line,
      input logic [NUM_WAYS-1:0] vld);
    @(negedge clk_i);
    drive_line(idx, ways, tag, line, vld);
    @(negedge clk_i);
    wr_cl_vld_i = 1'b0;
    wr_cl_we_i  = '0;
  endtask

  // byte enable merge of a word write into the model
  task automatic merge_word(input logic [IDX_WIDTH-1:0] idx, input logic [NUM_WAYS-1:0] ways,
      input logic [OFFSET_WIDTH-1:0] off, input logic [WORD_WIDTH-1:0] data,
      input logic [WORD_BYTES-1:0] be);
    for (int w = 0; w < NUM_WAYS; w++) begin
      for (int b = 0; b < WORD_BYTES; b++) begin
        if (ways[w] && be[b]) begin
          model_word[idx][w][off[OFFSET_WIDTH-1 -: BANK_SEL_WIDTH]][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
  endtask

  // one read on one port with its tag in the cycle after the grant
  task automatic read_word(input string test, input int port, input logic [IDX_WIDTH-1:0] idx,
      input logic [BANK_SEL_WIDTH-1:0] bank, input logic [TAG_WIDTH-1:0] tag,
      input logic tag_only);
    @(negedge clk_i);
    rd_req_i[port]      = 1'b1;
    rd_idx_i[port]      = idx;
    rd_off_i[port]      = {bank, 2'($urandom)};
    rd_tag_only_i[port] = tag_only;
    wait_read_ack(test, port);
    @(negedge clk_i);
    rd_req_i[port] = 1'b0;
    rd_tag_i[port] = tag;
    #1;
    check_read(test, idx, bank, tag, tag_only);
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic test_fill_hit();
    int w;
    for (int s = 0; s < 6; s++) begin
      for (int k = 0; k < 2; k++) begin
        w = (s + 2 * k) % NUM_WAYS;
        write_line(IDX_WIDTH'(s), NUM_WAYS'(1) << w, make_tag(w), random_line(),
                   NUM_WAYS'(1) << w);
      end
    end
    // every word of every written way spread over the ports
    for (int s = 0; s < 6; s++) begin
      for (int k = 0; k < 2; k++) begin
        w = (s + 2 * k) % NUM_WAYS;
        for (int b = 0; b < NUM_BANKS; b++) begin
          read_word("fill_hit", (s + b) % NUM_PORTS, IDX_WIDTH'(s), BANK_SEL_WIDTH'(b),
                    model_tag[s][w], 1'b0);
        end
      end
    end
  endtask

  task automatic test_miss_tag_only();
    read_word("miss", 0, IDX_WIDTH'(12), 2'd1, TAG_WIDTH'($urandom), 1'b0);
    read_word("miss", 1, IDX_WIDTH'(0), 2'd2, model_tag[0][0] ^ 8'h80, 1'b0);
    read_word("tag_only", 2, IDX_WIDTH'(1), 2'd3, model_tag[1][1], 1'b1);
  endtask

  task automatic test_arbitration();
    @(negedge clk_i);
    rd_tag_only_i = '1;
    rd_req_i      = '1;
    for (int c = 0; c < 9; c++) begin
      // port 1 alone at high priority and then ports 0 and 2 sharing
      if (c == 3) begin
        rd_prio_i = 3'b010;
      end
      if (c == 6) begin
        rd_prio_i = 3'b101;
      end
      #1;
      check_ack("arbitration");
      @(negedge clk_i);
    end
    // line write with all reads pending
    drive_line(IDX_WIDTH'(7), 4'b0001, make_tag(0), random_line(), 4'b0001);
    #1;
    check_ack("arbitration");
    @(negedge clk_i);
    wr_cl_vld_i = 1'b0;
    wr_cl_we_i  = '0;
    #1;
    check_ack("arbitration");
    @(negedge clk_i);
    rd_req_i      = '0;
    rd_prio_i     = '0;
    rd_tag_only_i = '0;
  endtask

  task automatic test_word_write();
    logic [WORD_WIDTH-1:0] data;
    // read bank 1 while writing bank 2 of set 2
    data = $urandom;
    @(negedge clk_i);
    rd_req_i[0]      = 1'b1;
    rd_idx_i[0]      = IDX_WIDTH'(2);
    rd_off_i[0]      = 4'h4;
    rd_tag_only_i[0] = 1'b0;
    wr_req_i         = 4'b0100;
    wr_idx_i         = IDX_WIDTH'(2);
    wr_off_i         = 4'h8;
    wr_data_i        = data;
    wr_be_i          = 4'b0101;
    wait_read_ack("word_write", 0);
    check("word_write", "write ack", 64'(1), 64'(wr_ack_o));
    merge_word(IDX_WIDTH'(2), 4'b0100, 4'h8, data, 4'b0101);
    @(negedge clk_i);
    rd_req_i    = '0;
    wr_req_i    = '0;
    rd_tag_i[0] = model_tag[2][2];
    #1;
    check_read("word_write", IDX_WIDTH'(2), 2'd1, model_tag[2][2], 1'b0);

    // the write waits on the same bank until the read goes away
    data = $urandom;
    @(negedge clk_i);
    rd_req_i[0] = 1'b1;
    rd_off_i[0] = 4'h8;
    wr_req_i    = 4'b0001;
    wr_off_i    = 4'hb;
    wr_data_i   = data;
    wr_be_i     = 4'b1010;
    for (int c = 0; c < 3; c++) begin
      wait_read_ack("word_collision", 0);
      check("word_collision", "write ack", 64'(0), 64'(wr_ack_o));
      @(negedge clk_i);
    end
    rd_req_i = '0;
    wait_write_ack();
    merge_word(IDX_WIDTH'(2), 4'b0001, 4'hb, data, 4'b1010);
    @(negedge clk_i);
    wr_req_i = '0;
    read_word("word_write", 1, IDX_WIDTH'(2), 2'd2, model_tag[2][2], 1'b0);
    read_word("word_collision", 2, IDX_WIDTH'(2), 2'd2, model_tag[2][0], 1'b0);
  endtask

  task automatic test_invalidate_overlap();
    int                        port;
    int                        prev_port;
    logic [IDX_WIDTH-1:0]      prev_idx;
    logic [BANK_SEL_WIDTH-1:0] prev_bank;
    logic [TAG_WIDTH-1:0]      prev_tag;
    logic [TAG_WIDTH-1:0]      tag;
    tag = model_tag[3][3];
    write_line(IDX_WIDTH'(3), 4'b1000, tag, random_line(), 4'b0000);
    read_word("invalidate", 1, IDX_WIDTH'(3), 2'd0, tag, 1'b0);

    // a new read each cycle on ports 0 and 2
    port      = 0;
    prev_port = 0;
    prev_idx  = '0;
    prev_bank = '0;
    prev_tag  = '0;
    @(negedge clk_i);
    for (int i = 0; i <= 6; i++) begin
      rd_req_i = '0;
      if (i > 0) begin
        rd_tag_i[prev_port] = prev_tag;
      end
      if (i < 6) begin
        port                = 2 * (i % 2);
        rd_req_i[port]      = 1'b1;
        rd_idx_i[port]      = IDX_WIDTH'(i);
        rd_off_i[port]      = {BANK_SEL_WIDTH'(i + 1), 2'b00};
        rd_tag_only_i[port] = 1'b0;
      end
      #1;
      if (i > 0) begin
        check_read("overlap", prev_idx, prev_bank, prev_tag, 1'b0);
      end
      if (i < 6) begin
        check_ack("overlap");
        prev_port = port;
        prev_idx  = IDX_WIDTH'(i);
        prev_bank = BANK_SEL_WIDTH'(i + 1);
        prev_tag  = model_tag[i][i % NUM_WAYS];
      end
      @(negedge clk_i);
    end
  endtask

// ==== verif/dcache_mem_tb.sv ====
////////////////////////////////////////
// dcache memory testbench: clock, reset,
// DUT, reference model of tags, valid
// bits and words, check and wait tasks
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dcache_mem_tb import dcache_mem_pkg::*; ();

  localparam int ACK_TIMEOUT = 20;
  localparam int SEED        = 8;

  logic                                   clk_i;
  logic                                   rst_ni;
  logic [NUM_PORTS-1:0]                   rd_req_i;
  logic [NUM_PORTS-1:0]                   rd_prio_i;
  logic [NUM_PORTS-1:0]                   rd_tag_only_i;
  logic [NUM_PORTS-1:0][IDX_WIDTH-1:0]    rd_idx_i;
  logic [NUM_PORTS-1:0][OFFSET_WIDTH-1:0] rd_off_i;
  logic [NUM_PORTS-1:0][TAG_WIDTH-1:0]    rd_tag_i;
  logic [NUM_PORTS-1:0]                   rd_ack_o;
  logic [NUM_WAYS-1:0]                    rd_vld_bits_o;
  logic [NUM_WAYS-1:0]                    rd_hit_oh_o;
  logic [WORD_WIDTH-1:0]                  rd_data_o;
  logic                                   wr_cl_vld_i;
  logic [NUM_WAYS-1:0]                    wr_cl_we_i;
  logic [IDX_WIDTH-1:0]                   wr_cl_idx_i;
  logic [TAG_WIDTH-1:0]                   wr_cl_tag_i;
  logic [LINE_WIDTH-1:0]                  wr_cl_data_i;
  logic [LINE_BYTES-1:0]                  wr_cl_be_i;
  logic [NUM_WAYS-1:0]                    wr_vld_bits_i;
  logic [NUM_WAYS-1:0]                    wr_req_i;
  logic [IDX_WIDTH-1:0]                   wr_idx_i;
  logic [OFFSET_WIDTH-1:0]                wr_off_i;
  logic [WORD_WIDTH-1:0]                  wr_data_i;
  logic [WORD_BYTES-1:0]                  wr_be_i;
  logic                                   wr_ack_o;

  // reference model of the cache contents and the round robin pointer
  logic [TAG_WIDTH-1:0]  model_tag  [NUM_SETS][NUM_WAYS];
  logic                  model_vld  [NUM_SETS][NUM_WAYS];
  logic [WORD_WIDTH-1:0] model_word [NUM_SETS][NUM_WAYS][NUM_BANKS];
  int                    rr_ptr;

  dcache_mem_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // model
  ////////////////////////////////////////

  function automatic logic [NUM_WAYS-1:0] expected_hit(input logic [IDX_WIDTH-1:0] idx,
      input logic [TAG_WIDTH-1:0] tag);
    logic [NUM_WAYS-1:0] hit;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit[w] = model_vld[idx][w] && (model_tag[idx][w] == tag);
    end
    return hit;
  endfunction

  // high priority requesters compete alone, first one at or after the pointer wins
  function automatic logic [NUM_PORTS-1:0] expected_ack(input logic [NUM_PORTS-1:0] req,
      input logic [NUM_PORTS-1:0] prio, input int ptr, input logic line_write);
    logic [NUM_PORTS-1:0] comp;
    logic [NUM_PORTS-1:0] ack;
    int                   p;
    comp = (|(req & prio)) ? (req & prio) : req;
    ack  = '0;
    if (!line_write) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        p = (ptr + i) % NUM_PORTS;
        if (ack == '0 && comp[p]) begin
          ack[p] = 1'b1;
        end
      end
    end
    return ack;
  endfunction

  function automatic logic [TAG_WIDTH-1:0] make_tag(input int way);
    // low bits carry the way so that tags in one set never repeat
    return (TAG_WIDTH'($urandom) & ~TAG_WIDTH'(NUM_WAYS - 1)) | TAG_WIDTH'(way);
  endfunction

  function automatic logic [LINE_WIDTH-1:0] random_line();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  ////////////////////////////////////////
  // checks and waits
  ////////////////////////////////////////

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check(input string test, input string field, input logic [63:0] expected,
      input logic [63:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("Error in %s, %s: expected %0h, actual %0h",
                         test, field, expected, actual));
    end
  endtask

  task automatic check_ack(input string test);
    logic [NUM_PORTS-1:0] exp_ack;
    exp_ack = expected_ack(rd_req_i, rd_prio_i, rr_ptr, wr_cl_vld_i);
    check(test, "read ack", 64'(exp_ack), 64'(rd_ack_o));
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (exp_ack[p]) begin
        rr_ptr = (p + 1) % NUM_PORTS;
      end
    end
  endtask

  task automatic wait_read_ack(input string test, input int port);
    int cycles;
    cycles = 0;
    #1;
    while (!rd_ack_o[port] && cycles < ACK_TIMEOUT) begin
      @(negedge clk_i);
      #1;
      cycles++;
    end
    if (!rd_ack_o[port]) begin
      fail_run($sformatf("read port %0d got no ack within %0d cycles", port, ACK_TIMEOUT));
    end
    check_ack(test);
  endtask

  task automatic wait_write_ack();
    int cycles;
    cycles = 0;
    #1;
    while (!wr_ack_o && cycles < ACK_TIMEOUT) begin
      @(negedge clk_i);
      #1;
      cycles++;
    end
    if (!wr_ack_o) begin
      fail_run($sformatf("word write got no ack within %0d cycles", ACK_TIMEOUT));
    end
  endtask

  // result of a read in the cycle after its grant
  task automatic check_read(input string test, input logic [IDX_WIDTH-1:0] idx,
      input logic [BANK_SEL_WIDTH-1:0] bank, input logic [TAG_WIDTH-1:0] tag,
      input logic tag_only);
    logic [NUM_WAYS-1:0]   hit;
    logic [NUM_WAYS-1:0]   vld;
    logic [WORD_WIDTH-1:0] word;
    hit  = expected_hit(idx, tag);
    word = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      vld[w] = model_vld[idx][w];
      if (hit[w] && !tag_only) begin
        word |= model_word[idx][w][bank];
      end
    end
    check(test, "hit bits", 64'(hit), 64'(rd_hit_oh_o));
    check(test, "valid bits", 64'(vld), 64'(rd_vld_bits_o));
    check(test, "read data", 64'(word), 64'(rd_data_o));
  endtask

  `include "dcache_mem_tests.svh"

  ////////////////////////////////////////
  // run order
  ////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    rst_ni        = 1'b0;
    rd_req_i      = '0;
    rd_prio_i     = '0;
    rd_tag_only_i = '0;
    rd_idx_i      = '0;
    rd_off_i      = '0;
    rd_tag_i      = '0;
    wr_cl_vld_i   = 1'b0;
    wr_cl_we_i    = '0;
    wr_cl_idx_i   = '0;
    wr_cl_tag_i   = '0;
    wr_cl_data_i  = '0;
    wr_cl_be_i    = '0;
    wr_vld_bits_i = '0;
    wr_req_i      = '0;
    wr_idx_i      = '0;
    wr_off_i      = '0;
    wr_data_i     = '0;
    wr_be_i       = '0;
    rr_ptr        = 0;
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        model_vld[s][w] = 1'b0;
        model_tag[s][w] = '0;
      end
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check("reset", "read ack", 64'(0), 64'(rd_ack_o));
    check("reset", "write ack", 64'(0), 64'(wr_ack_o));
    check("reset", "hit bits", 64'(0), 64'(rd_hit_oh_o));
    check("reset", "valid bits", 64'(0), 64'(rd_vld_bits_o));
    test_fill_hit();
    test_miss_tag_only();
    test_arbitration();
    test_word_write();
    test_invalidate_overlap();
    repeat (2) @(negedge clk_i);
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+verif
src/dcache_mem_pkg.sv
src/dcache_read_arbiter.sv
src/dcache_bank_ctrl.sv
src/dcache_data_bank.sv
src/dcache_tag_array.sv
src/dcache_read_mux.sv
src/dcache_mem_top.sv
verif/dcache_mem_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the dcache memory testbench with Verilator
# the exit status is nonzero when the testbench stops with $fatal
verilator --binary --timing --assert -j 0 \
  --top-module dcache_mem_tb -f src.f -o dcache_mem_sim \
  && ./obj_dir/dcache_mem_sim \
  || { echo "simulation did not complete cleanly"; exit 1; }
